// File: Makefile
# Verilator build and run for the RV32I debug subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_debug_top
FILELIST  ?= rv_debug_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/disp_pkg.sv
// Store buffer and display records
// A posted store as queued in the buffer, and a 7-segment pattern

`include "rv_macros.svh"

package disp_pkg;

  // Address and data of one store, 64 bits
  typedef struct packed {
    logic [`XLEN-1:0] adr;
    logic [`XLEN-1:0] dat;
  } store_rec_t;

  // Active low, bit 0 is segment a
  typedef logic [6:0] seg_t;

endpackage

// File: design/hex_display.sv
// Hex display for posted stores
// Pulls one record per hold period and shows 16 bits on four digits

`timescale 1ns/1ps
`include "rv_macros.svh"

module hex_display (
  input  logic                clk,
  input  logic                rst_n,
  wb_if.master                rd,
  input  logic                show_high,
  output disp_pkg::seg_t      hex0,
  output disp_pkg::seg_t      hex1,
  output disp_pkg::seg_t      hex2,
  output disp_pkg::seg_t      hex3,
  output logic                disp_valid,
  output logic [`XLEN-1:0]    disp_adr
);

  localparam int HW = $clog2(`DISP_HOLD + 1);

  logic                   rd_stb;
  logic [HW-1:0]          hold_cnt;
  logic [`XLEN-1:0]       shown_dat;
  logic [`XLEN/2-1:0]     half;

  // Standard hex font, active low
  function automatic disp_pkg::seg_t seg_font(input logic [3:0] nib);
    case (nib)
      4'h0: seg_font = 7'h40;
      4'h1: seg_font = 7'h79;
      4'h2: seg_font = 7'h24;
      4'h3: seg_font = 7'h30;
      4'h4: seg_font = 7'h19;
      4'h5: seg_font = 7'h12;
      4'h6: seg_font = 7'h02;
      4'h7: seg_font = 7'h78;
      4'h8: seg_font = 7'h00;
      4'h9: seg_font = 7'h10;
      4'hA: seg_font = 7'h08;
      4'hB: seg_font = 7'h03;
      4'hC: seg_font = 7'h46;
      4'hD: seg_font = 7'h21;
      4'hE: seg_font = 7'h06;
      default: seg_font = 7'h0E;
    endcase
  endfunction

  // Read, then hold for DISP_HOLD cycles before the next read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_stb     <= 1'b0;
      hold_cnt   <= '0;
      disp_valid <= 1'b0;
      shown_dat  <= '0;
      disp_adr   <= '0;
    end else begin
      disp_valid <= 1'b0;
      if (rd_stb && rd.ack) begin
        rd_stb     <= 1'b0;
        shown_dat  <= rd.dat_r;
        disp_adr   <= rd.adr_r;
        disp_valid <= 1'b1;
        hold_cnt   <= HW'(`DISP_HOLD);
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - 1'b1;
      end else if (!rd_stb) begin
        rd_stb <= 1'b1;
      end
    end
  end

  assign rd.cyc   = rd_stb;
  assign rd.stb   = rd_stb;
  assign rd.we    = 1'b0;
  assign rd.adr   = '0;
  assign rd.dat_w = '0;

  assign half = show_high ? shown_dat[`XLEN-1:`XLEN/2] : shown_dat[`XLEN/2-1:0];

  assign hex0 = seg_font(half[3:0]);
  assign hex1 = seg_font(half[7:4]);
  assign hex2 = seg_font(half[11:8]);
  assign hex3 = seg_font(half[15:12]);

  a_no_stb_during_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !rd.stb && hold_cnt != '0 |=> !rd.stb);

endmodule

// File: design/rv_core.sv
// Multicycle RV32I subset core
// Fetches over the instruction bus, posts stores on a Wishbone master

`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core (
  input  logic             clk,
  input  logic             rst_n,
  output logic             ibus_cyc,
  output logic             ibus_stb,
  output logic [`XLEN-1:0] ibus_adr,
  input  logic [`XLEN-1:0] ibus_dat_r,
  input  logic             ibus_ack,
  wb_if.master             dbus
);

  localparam int RW = $clog2(`NREGS);

  typedef enum logic [1:0] {ST_FETCH, ST_EXECUTE, ST_STORE} state_e;

  state_e             state;
  logic               fetch_stb;
  logic [`XLEN-1:0]   pc;
  rv_pkg::instr_u     instr;
  logic [`XLEN-1:0]   regs [`NREGS];

  // Store request held on dbus
  logic               st_stb;
  logic [`XLEN-1:0]   st_adr;
  logic [`XLEN-1:0]   st_dat;

  logic [RW-1:0]      rs1_idx, rs2_idx, rd_idx;
  logic [`XLEN-1:0]   rs1_val, rs2_val;
  logic [`XLEN-1:0]   imm_i, imm_s, imm_b, imm_u;
  logic [`XLEN-1:0]   alu_b, alu_y;
  rv_pkg::alu_op_e    alu_op;
  logic               rd_we, is_store, is_branch, br_taken;

  // ====================
  // Decode
  // ====================
  assign rs1_idx = instr.r.rs1;
  assign rs2_idx = instr.r.rs2;
  assign rd_idx  = instr.r.rd;

  // x0 reads as zero
  assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
  assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
  assign imm_u = {instr.u.imm31_12, 12'b0};

  always_comb begin
    alu_op    = rv_pkg::ALU_NONE;
    alu_b     = rs2_val;
    rd_we     = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    br_taken  = 1'b0;
    case (instr.r.opcode)
      rv_pkg::OPC_OP: begin
        rd_we = 1'b1;
        case (instr.r.funct3)
          3'b000:  alu_op = instr.r.funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
          3'b001:  alu_op = rv_pkg::ALU_SLL;
          3'b010:  alu_op = rv_pkg::ALU_SLT;
          3'b100:  alu_op = rv_pkg::ALU_XOR;
          3'b101:  alu_op = rv_pkg::ALU_SRL;
          3'b110:  alu_op = rv_pkg::ALU_OR;
          3'b111:  alu_op = rv_pkg::ALU_AND;
          default: rd_we  = 1'b0;
        endcase
      end
      rv_pkg::OPC_OP_IMM: begin
        rd_we = 1'b1;
        alu_b = imm_i;
        case (instr.i.funct3)
          3'b000:  alu_op = rv_pkg::ALU_ADD;
          3'b100:  alu_op = rv_pkg::ALU_XOR;
          3'b110:  alu_op = rv_pkg::ALU_OR;
          3'b111:  alu_op = rv_pkg::ALU_AND;
          default: rd_we  = 1'b0;
        endcase
      end
      rv_pkg::OPC_LUI: begin
        rd_we  = 1'b1;
        alu_b  = imm_u;
        alu_op = rv_pkg::ALU_PASS_B;
      end
      rv_pkg::OPC_STORE: is_store = 1'b1;
      rv_pkg::OPC_BRANCH: begin
        is_branch = 1'b1;
        // BEQ on funct3 0, BNE on funct3 1
        case (instr.b.funct3)
          3'b000:  br_taken = (rs1_val == rs2_val);
          3'b001:  br_taken = (rs1_val != rs2_val);
          default: br_taken = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (alu_op)
      rv_pkg::ALU_ADD:    alu_y = rs1_val + alu_b;
      rv_pkg::ALU_SUB:    alu_y = rs1_val - alu_b;
      rv_pkg::ALU_AND:    alu_y = rs1_val & alu_b;
      rv_pkg::ALU_OR:     alu_y = rs1_val | alu_b;
      rv_pkg::ALU_XOR:    alu_y = rs1_val ^ alu_b;
      rv_pkg::ALU_SLT:    alu_y = `XLEN'($signed(rs1_val) < $signed(alu_b));
      rv_pkg::ALU_SLL:    alu_y = rs1_val << alu_b[4:0];
      rv_pkg::ALU_SRL:    alu_y = rs1_val >> alu_b[4:0];
      rv_pkg::ALU_PASS_B: alu_y = alu_b;
      default:            alu_y = '0;
    endcase
  end

  // ====================
  // Control
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_FETCH;
      fetch_stb <= 1'b0;
      st_stb    <= 1'b0;
      pc        <= '0;
    end else begin
      case (state)
        ST_FETCH: begin
          if (fetch_stb && ibus_ack) begin
            fetch_stb <= 1'b0;
            state     <= ST_EXECUTE;
          end else if (!fetch_stb) begin
            fetch_stb <= 1'b1;
          end
        end
        ST_EXECUTE: begin
          if (is_branch && br_taken)
            pc <= pc + imm_b;
          else
            pc <= pc + `XLEN'(4);
          if (is_store) begin
            st_stb <= 1'b1;
            state  <= ST_STORE;
          end else begin
            fetch_stb <= 1'b1;
            state     <= ST_FETCH;
          end
        end
        ST_STORE: begin
          // Stalls here while the buffer is full
          if (dbus.ack) begin
            st_stb    <= 1'b0;
            fetch_stb <= 1'b1;
            state     <= ST_FETCH;
          end
        end
        default: state <= ST_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_FETCH && fetch_stb && ibus_ack)
      instr <= ibus_dat_r;
    if (state == ST_EXECUTE && is_store) begin
      st_adr <= rs1_val + imm_s;
      st_dat <= rs2_val;
    end
  end

  // Register file, writes to x0 dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NREGS; i++)
        regs[i] <= '0;
    end else if (state == ST_EXECUTE && rd_we && rd_idx != '0) begin
      regs[rd_idx] <= alu_y;
    end
  end

  assign ibus_cyc = fetch_stb;
  assign ibus_stb = fetch_stb;
  assign ibus_adr = pc;

  assign dbus.cyc   = st_stb;
  assign dbus.stb   = st_stb;
  assign dbus.we    = 1'b1;
  assign dbus.adr   = st_adr;
  assign dbus.dat_w = st_dat;

  a_ibus_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ibus_stb && !ibus_ack |=> $stable(ibus_adr));

  a_dbus_only_in_store: assert property (@(posedge clk) disable iff (!rst_n)
    dbus.stb |-> state == ST_STORE);

endmodule

// File: design/rv_debug_top.sv
// RISC-V debug subsystem top level
// Core stores flow through the store buffer to the hex display

`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_debug_top (
  input  logic             clk,
  input  logic             rst_n,
  output logic             ibus_cyc,
  output logic             ibus_stb,
  output logic [`XLEN-1:0] ibus_adr,
  input  logic [`XLEN-1:0] ibus_dat_r,
  input  logic             ibus_ack,
  input  logic             show_high,
  output disp_pkg::seg_t   hex0,
  output disp_pkg::seg_t   hex1,
  output disp_pkg::seg_t   hex2,
  output disp_pkg::seg_t   hex3,
  output logic             disp_valid,
  output logic [`XLEN-1:0] disp_adr
);

  // Core to buffer, buffer to display
  wb_if dbus ();
  wb_if dispbus ();

  rv_core i_rv_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .ibus_cyc   (ibus_cyc),
    .ibus_stb   (ibus_stb),
    .ibus_adr   (ibus_adr),
    .ibus_dat_r (ibus_dat_r),
    .ibus_ack   (ibus_ack),
    .dbus       (dbus.master)
  );

  store_fifo i_store_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (dbus.slave),
    .rd    (dispbus.slave)
  );

  hex_display i_hex_display (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd         (dispbus.master),
    .show_high  (show_high),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .disp_valid (disp_valid),
    .disp_adr   (disp_adr)
  );

endmodule

// File: design/rv_macros.svh
// Shared sizing constants for the RV32I debug subsystem
// Data width, register file size, store buffer depth, display hold

`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data and address width
`define XLEN       32
`define NREGS      32
`define FIFO_DEPTH 4
// Cycles a shown word stays before the next read
`define DISP_HOLD  16

`endif

// File: design/rv_pkg.sv
// RV32I subset ISA definitions
// Major opcodes, ALU functions and the instruction format views

package rv_pkg;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // ALU_NONE marks an unsupported encoding
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B, ALU_NONE
  } alu_op_e;

  // ====================
  // Instruction formats
  // ====================
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  // One fetched word, read through whichever format the opcode selects
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
  } instr_u;

endpackage

// File: design/store_fifo.sv
// Store buffer between the core and the hex display
// In-order queue of store records with a Wishbone slave on each side

`timescale 1ns/1ps
`include "rv_macros.svh"

module store_fifo (
  input  logic clk,
  input  logic rst_n,
  wb_if.slave  wr,
  wb_if.slave  rd
);

  localparam int DEPTH = `FIFO_DEPTH;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  disp_pkg::store_rec_t mem [DEPTH];
  disp_pkg::store_rec_t rd_rec;

  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  logic          full, empty;
  logic          push, pop;
  logic          wr_ack, rd_ack;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  // Ack one cycle after the request, never twice for one strobe
  assign push = wr.cyc && wr.stb && wr.we && !wr_ack && !full;
  assign pop  = rd.cyc && rd.stb && !rd.we && !rd_ack && !empty;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      wr_ack <= 1'b0;
      rd_ack <= 1'b0;
    end else begin
      wr_ack <= push;
      rd_ack <= pop;
      if (push)
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(push) - CW'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= '{adr: wr.adr, dat: wr.dat_w};
    if (pop)
      rd_rec <= mem[rd_ptr];
  end

  assign wr.ack   = wr_ack;
  assign wr.dat_r = '0;
  assign wr.adr_r = '0;

  assign rd.ack   = rd_ack;
  assign rd.dat_r = rd_rec.dat;
  assign rd.adr_r = rd_rec.adr;

  a_no_wr_ack_full: assert property (@(posedge clk) disable iff (!rst_n)
    full |=> !wr.ack);

  a_no_rd_ack_empty: assert property (@(posedge clk) disable iff (!rst_n)
    empty |=> !rd.ack);

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CW'(DEPTH));

endmodule

// File: design/wb_if.sv
// Wishbone classic bus between design blocks
// adr_r returns the record address alongside dat_r on reads

`timescale 1ns/1ps
`include "rv_macros.svh"

interface wb_if;

  logic             cyc;
  logic             stb;
  logic             we;
  logic [`XLEN-1:0] adr;
  logic [`XLEN-1:0] dat_w;
  logic [`XLEN-1:0] dat_r;
  logic [`XLEN-1:0] adr_r;
  logic             ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, adr_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, adr_r, ack
  );

endinterface

// File: dv/rv_testdata.hex
// @00: program words, four per line in fetch order
// @40: expected stores as address data pairs; @7E: program length, store count
@00
89ABD0B7 DEF08093 01234137 56710113 // x1 = 89ABCDEF, x2 = 01234567
001081B3 40110233 0020A2B3 00C00313 // ADD and SUB wrap, SLT signed, x6 = 12
006113B3 0060D433 0020C4B3 0040F533 // SLL, SRL by x6, XOR, AND
0051E5B3 FFF0C613 0F00F693 7F02E713 // OR, XORI, ANDI, ORI
00508013 10102023 10202223 10302423 // ADDI into x0, store burst starts
10402623 10502823 10702A23 00028463 // burst of six, BEQ not taken
10802C23 00029463 7E102E23 10902E23 // BNE taken skips one store
00000463 7E102C23 12002023 12A02223 // BEQ taken skips one, store of x0
12B02423 12C02623 12D02823 12E02A23
00000063                            // BEQ self loop
@40
00000100 89ABCDEF 00000104 01234567
00000108 13579BDE 0000010C 77777778
00000110 00000001 00000114 34567000
00000118 00089ABC 0000011C 88888888
00000120 00000000 00000124 01234568
00000128 13579BDF 0000012C 76543210
00000130 000000E0 00000134 000007F1
@7E
00000025 0000000E

// File: dv/tb_rv_debug_top.sv
// Testbench for the RV32I debug subsystem
// Serves the program on the instruction bus with random wait states,
// then checks every displayed store against the expected list

`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_rv_debug_top;

  // Test data layout with one 32-bit word per entry
  localparam int MEM_WORDS = 128;
  localparam int EXP_BASE  = 'h40;
  localparam int LEN_IDX   = 'h7E;
  localparam int CNT_IDX   = 'h7F;

  // Active low hex font with bit 0 as segment a
  localparam disp_pkg::seg_t FONT [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic             clk;
  logic             rst_n;
  logic             ibus_cyc;
  logic             ibus_stb;
  logic [`XLEN-1:0] ibus_adr;
  logic [`XLEN-1:0] ibus_dat_r;
  logic             ibus_ack;
  logic             show_high;
  disp_pkg::seg_t   hex0, hex1, hex2, hex3;
  logic             disp_valid;
  logic [`XLEN-1:0] disp_adr;

  logic [31:0]      tdata [MEM_WORDS];
  int unsigned      prog_len;
  int unsigned      n_stores;
  logic [31:0]      rng_state;

  rv_debug_top i_rv_debug_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .ibus_cyc   (ibus_cyc),
    .ibus_stb   (ibus_stb),
    .ibus_adr   (ibus_adr),
    .ibus_dat_r (ibus_dat_r),
    .ibus_ack   (ibus_ack),
    .show_high  (show_high),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .disp_valid (disp_valid),
    .disp_adr   (disp_adr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_adr(input string name, input logic [`XLEN-1:0] exp,
                           input logic [`XLEN-1:0] act);
    if (act !== exp)
      stop_run($sformatf("MISMATCH %s expected %08h actual %08h", name, exp, act));
  endtask

  task automatic check_seg(input string name, input disp_pkg::seg_t exp,
                           input disp_pkg::seg_t act);
    if (act !== exp)
      stop_run($sformatf("MISMATCH %s expected %02h actual %02h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
      stop_run($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
  endtask

  // hex0 carries the lowest nibble
  task automatic check_digits(input string tag, input logic [15:0] half);
    check_seg({tag, " hex0"}, FONT[half[3:0]], hex0);
    check_seg({tag, " hex1"}, FONT[half[7:4]], hex1);
    check_seg({tag, " hex2"}, FONT[half[11:8]], hex2);
    check_seg({tag, " hex3"}, FONT[half[15:12]], hex3);
  endtask

  // ====================
  // Instruction bus slave
  // ====================
  initial begin : ibus_slave
    int unsigned delay;
    rng_state = 32'd55872;
    forever begin
      @(posedge clk);
      if (rst_n && ibus_stb && !ibus_ack) begin
        // A classic cycle needs cyc along with stb
        check_flag("ibus_cyc with ibus_stb", 1'b1, ibus_cyc);
        rng_state = xorshift32(rng_state);
        delay = rng_state % 4;
        repeat (delay) @(posedge clk);
        if (ibus_adr[1:0] != 2'b00 || (ibus_adr >> 2) >= prog_len)
          stop_run($sformatf("core fetched outside the program at %08h", ibus_adr));
        ibus_dat_r <= tdata[ibus_adr[8:2]];
        ibus_ack   <= 1'b1;
        @(posedge clk);
        ibus_ack   <= 1'b0;
      end
    end
  end

  // Budget grows with the number of stores and the program length
  initial begin : watchdog
    longint unsigned limit;
    @(posedge rst_n);
    limit = (longint'(n_stores) + 1) * (`DISP_HOLD + 64 * longint'(prog_len));
    repeat (limit) @(posedge clk);
    stop_run($sformatf("timeout, display stalled within %0d cycles", limit));
  end

  // ====================
  // Main sequence
  // ====================
  initial begin : main_seq
    logic [`XLEN-1:0] exp_adr;
    logic [`XLEN-1:0] exp_dat;
    rst_n      = 1'b0;
    ibus_ack   = 1'b0;
    ibus_dat_r = '0;
    show_high  = 1'b0;
    $readmemh("dv/rv_testdata.hex", tdata);
    if ($isunknown(tdata[LEN_IDX]) || $isunknown(tdata[CNT_IDX]))
      stop_run("test data file is missing or incomplete");
    prog_len = tdata[LEN_IDX];
    n_stores = tdata[CNT_IDX];

    // Display must stay blank at zero through reset
    repeat (8) begin
      @(negedge clk);
      check_flag("reset disp_valid", 1'b0, disp_valid);
      check_digits("reset", 16'h0000);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("after reset disp_valid", 1'b0, disp_valid);
    check_digits("after reset", 16'h0000);

    for (int i = 0; i < n_stores; i++) begin
      exp_adr = tdata[EXP_BASE + 2 * i];
      exp_dat = tdata[EXP_BASE + 2 * i + 1];
      do @(negedge clk); while (!disp_valid);
      check_adr($sformatf("store %0d adr", i), exp_adr, disp_adr);
      check_digits($sformatf("store %0d low", i), exp_dat[15:0]);
      @(posedge clk);
      show_high <= 1'b1;
      @(negedge clk);
      check_digits($sformatf("store %0d high", i), exp_dat[31:16]);
      @(posedge clk);
      show_high <= 1'b0;
    end

    // Core sits in its self loop so no further store may show up
    repeat (4 * (`DISP_HOLD + 16)) begin
      @(negedge clk);
      if (disp_valid)
        stop_run("display showed a store beyond the expected list");
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: rv_debug_top.f
+incdir+design
design/rv_pkg.sv
design/disp_pkg.sv
design/wb_if.sv
design/rv_core.sv
design/store_fifo.sv
design/hex_display.sv
design/rv_debug_top.sv
dv/tb_rv_debug_top.sv
